// ==== hdl/switch_params.svh ====
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// ----------------------------------------------------------
// Stream switch sizing
// ----------------------------------------------------------

// Number of input flows feeding the switch
`define NUM_FLOWS 4

// Width of one data beat in bits
`define DATA_WIDTH 16

// Width of the burst length field
// Holds 1 to 15 beats, a zero length counts as one beat
`define BEATS_WIDTH 4

`endif

// ==== hdl/flowPkg.sv ====
`include "switch_params.svh"

// ----------------------------------------------------------
// Data path types shared by the mux and the output register
// ----------------------------------------------------------
package flowPkg;

  // Index width for the flow select
  // Never below one bit so a single flow still has a legal index
  localparam int FlowIdxWidth = (`NUM_FLOWS > 1) ? $clog2(`NUM_FLOWS) : 1;

  // Binary flow index
  typedef logic [FlowIdxWidth-1:0] flowIdxT;

  // One beat of payload
  typedef logic [`DATA_WIDTH-1:0] dataWordT;

endpackage : flowPkg

// ==== hdl/cmdPkg.sv ====
`include "switch_params.svh"

// ----------------------------------------------------------
// Command types for the burst sequencer
// ----------------------------------------------------------
package cmdPkg;

  import flowPkg::*;

  // Requested burst length
  typedef logic [`BEATS_WIDTH-1:0] beatCountT;

  // One steering command
  // Flow in the upper bits, length in the lower bits
  typedef struct packed {
    flowIdxT   flow;
    beatCountT beats;
  } burstCmdT;

  // Number of beats a command really moves
  // A zero length still forwards a single beat
  function automatic beatCountT effectiveBeats(beatCountT beats);
    return (beats == '0) ? beatCountT'(1) : beats;
  endfunction

endpackage : cmdPkg

// ==== hdl/flowRegFwd.sv ====
`timescale 1ns/1ps

// ----------------------------------------------------------
// Single entry forward register on a ready-valid link
// ----------------------------------------------------------
// Pop valid and pop data come straight from flops
// Push ready still follows pop ready combinationally
module flowRegFwd #(
  parameter type PayloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    pushValid,
  output logic    pushReady,
  input  PayloadT pushData,
  output logic    popValid,
  input  logic    popReady,
  output PayloadT popData
);

  // Occupancy flag
  logic    validQ;
  // Held payload
  PayloadT dataQ;
  // Push side handshake completes this cycle
  logic    pushXfer;

  // Room when empty or when the held item leaves this cycle
  assign pushReady = !validQ || popReady;
  assign pushXfer  = pushValid && pushReady;

  // ----------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------
  // Whenever there is room the flag takes the push valid
  // Covers fill, drain and back to back refill
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ <= 1'b0;
    end else if (pushReady) begin
      validQ <= pushValid;
    end
  end

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------
  // Loads only on a push transfer
  // Upstream data that wobbles while valid is low never gets through
  always_ff @(posedge clk) begin
    if (pushXfer) begin
      dataQ <= pushData;
    end
  end

  assign popValid = validQ;
  assign popData  = dataQ;

endmodule : flowRegFwd

// ==== hdl/burstSelectDecode.sv ====
`timescale 1ns/1ps

// ----------------------------------------------------------
// Burst sequencer
// ----------------------------------------------------------
// Takes one command at a time
// Holds the flow select and counts down the remaining beats
// Goes back to idle after the last beat of the burst
module burstSelectDecode (
  input  logic             clk,
  input  logic             arstN,
  input  logic             regCmdValid,
  output logic             regCmdReady,
  input  cmdPkg::burstCmdT regCmd,
  output flowPkg::flowIdxT select,
  output logic             selectActive,
  input  logic             beatTaken
);

  import cmdPkg::*;

  typedef enum logic {
    Idle,
    Active
  } stateT;

  stateT     stateQ;
  stateT     stateD;
  beatCountT beatsLeftQ;
  beatCountT beatsLeftD;
  // Command handshake with the command register
  logic      cmdXfer;
  // Final beat of the burst moves this cycle
  logic      lastBeat;

  // Commands are only taken between bursts
  assign regCmdReady = (stateQ == Idle);
  assign cmdXfer     = regCmdValid && regCmdReady;

  assign lastBeat = (stateQ == Active) && beatTaken && (beatsLeftQ == beatCountT'(1));

  // ----------------------------------------------------------
  // Next state and counter
  // ----------------------------------------------------------
  always_comb begin
    stateD     = stateQ;
    beatsLeftD = beatsLeftQ;
    unique case (stateQ)
      Idle: begin
        // Length zero becomes one here
        if (cmdXfer) begin
          stateD     = Active;
          beatsLeftD = effectiveBeats(regCmd.beats);
        end
      end
      Active: begin
        if (beatTaken) begin
          beatsLeftD = beatsLeftQ - beatCountT'(1);
        end
        // One idle cycle follows every burst
        if (lastBeat) begin
          stateD = Idle;
        end
      end
      default: begin
        stateD = Idle;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stateQ     <= Idle;
      beatsLeftQ <= '0;
      select     <= '0;
    end else begin
      stateQ     <= stateD;
      beatsLeftQ <= beatsLeftD;
      // Select is latched together with the length
      if (cmdXfer) begin
        select <= regCmd.flow;
      end
    end
  end

  // Mux is enabled for the whole burst
  assign selectActive = (stateQ == Active);

endmodule : burstSelectDecode

// ==== hdl/flowMuxSelectUnstable.sv ====
`timescale 1ns/1ps

`include "switch_params.svh"

// ----------------------------------------------------------
// Combinational select mux
// ----------------------------------------------------------
// Output valid and data may change without a transfer
// The register behind it hides that from the pop side
module flowMuxSelectUnstable (
  input  flowPkg::flowIdxT                   select,
  input  logic                               selectActive,
  input  logic [`NUM_FLOWS-1:0]              pushValid,
  output logic [`NUM_FLOWS-1:0]              pushReady,
  input  flowPkg::dataWordT [`NUM_FLOWS-1:0] pushData,
  output logic                               muxValid,
  input  logic                               muxReady,
  output flowPkg::dataWordT                  muxData
);

  // ----------------------------------------------------------
  // Forward path
  // ----------------------------------------------------------
  // Nothing leaves the mux between bursts
  always_comb begin
    muxValid = 1'b0;
    muxData  = '0;
    if (selectActive) begin
      muxValid = pushValid[select];
      muxData  = pushData[select];
    end
  end

  // ----------------------------------------------------------
  // Ready fan out
  // ----------------------------------------------------------
  // Only the selected flow sees downstream ready
  // Every other flow is held off
  always_comb begin
    for (int i = 0; i < `NUM_FLOWS; i++) begin
      pushReady[i] = selectActive && (int'(select) == i) && muxReady;
    end
  end

endmodule : flowMuxSelectUnstable

// ==== hdl/streamSwitch.sv ====
`timescale 1ns/1ps

`include "switch_params.svh"

// ----------------------------------------------------------
// Burst steered stream switch
// ----------------------------------------------------------
// A command names one input flow and a beat count
// That many beats of the flow go to the output in order
// The next command is taken once the burst is done
module streamSwitch (
  input  logic                               clk,
  input  logic                               arstN,

  // Command push side
  input  logic                               cmdValid,
  output logic                               cmdReady,
  input  cmdPkg::burstCmdT                   cmd,

  // Per flow data push side
  input  logic [`NUM_FLOWS-1:0]              pushValid,
  output logic [`NUM_FLOWS-1:0]              pushReady,
  input  flowPkg::dataWordT [`NUM_FLOWS-1:0] pushData,

  // Output pop side
  output logic                               popValid,
  input  logic                               popReady,
  output flowPkg::dataWordT                  popData
);

  import flowPkg::*;
  import cmdPkg::*;

  // Registered command into the sequencer
  logic     regCmdValid;
  logic     regCmdReady;
  burstCmdT regCmd;

  // Sequencer to mux
  flowIdxT  select;
  logic     selectActive;

  // Mux to output register
  logic     muxValid;
  logic     muxReady;
  dataWordT muxData;

  // One beat of the burst moves into the output register
  logic     beatTaken;

  // ----------------------------------------------------------
  // Command path
  // ----------------------------------------------------------
  // Lets the next command wait while a burst runs
  flowRegFwd #(
    .PayloadT(burstCmdT)
  ) cmdReg_i (
    .clk      (clk),
    .arstN    (arstN),
    .pushValid(cmdValid),
    .pushReady(cmdReady),
    .pushData (cmd),
    .popValid (regCmdValid),
    .popReady (regCmdReady),
    .popData  (regCmd)
  );

  burstSelectDecode decode_i (
    .clk         (clk),
    .arstN       (arstN),
    .regCmdValid (regCmdValid),
    .regCmdReady (regCmdReady),
    .regCmd      (regCmd),
    .select      (select),
    .selectActive(selectActive),
    .beatTaken   (beatTaken)
  );

  // ----------------------------------------------------------
  // Data path
  // ----------------------------------------------------------
  flowMuxSelectUnstable mux_i (
    .select      (select),
    .selectActive(selectActive),
    .pushValid   (pushValid),
    .pushReady   (pushReady),
    .pushData    (pushData),
    .muxValid    (muxValid),
    .muxReady    (muxReady),
    .muxData     (muxData)
  );

  // Counted on the mux handshake so stalls never cost a beat
  assign beatTaken = muxValid && muxReady;

  // Output valid and data straight from flops
  flowRegFwd #(
    .PayloadT(dataWordT)
  ) dataReg_i (
    .clk      (clk),
    .arstN    (arstN),
    .pushValid(muxValid),
    .pushReady(muxReady),
    .pushData (muxData),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData)
  );

endmodule : streamSwitch

// ==== bench/streamSwitchTb.sv ====
`timescale 1ns/1ps

`include "switch_params.svh"

module streamSwitchTb;

  import flowPkg::*;
  import cmdPkg::*;

  localparam time ClkPeriod     = 100ns;
  localparam time DriveDelay    = 10ns;
  localparam int  CyclesPerBeat = 20;
  localparam int  MarginCycles  = 200;
  // Low bits of a beat carry the per flow sequence number
  localparam int  SeqWidth      = `DATA_WIDTH - FlowIdxWidth;

  logic                      clk;
  logic                      arstN;
  logic                      cmdValid;
  logic                      cmdReady;
  burstCmdT                  cmd;
  logic [`NUM_FLOWS-1:0]     pushValid;
  logic [`NUM_FLOWS-1:0]     pushReady;
  dataWordT [`NUM_FLOWS-1:0] pushData;
  logic                      popValid;
  logic                      popReady;
  dataWordT                  popData;

  // Command table with one entry per row
  int       rowFlow[$];
  int       rowBeats[$];
  int       rowHold[$];
  bit       rowStalled[$];
  // Scoreboard
  dataWordT expWord[$];
  int       expRow[$];
  int       totalBeats;
  int       popCount;
  // Source and command progress
  int       seqNext[`NUM_FLOWS];
  int       cmdIdx;
  int       pushRow;
  int       pushCount;
  int       stallLeft;
  logic [31:0] rngState;
  // Handshakes seen at the last falling edge
  logic                  cmdXfer;
  logic [`NUM_FLOWS-1:0] pushXfer;
  logic                  popXfer;
  logic                  prevPopValid;
  logic                  prevPopReady;
  dataWordT              prevPopData;

  streamSwitch dut_i (
    .clk      (clk),
    .arstN    (arstN),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .cmd      (cmd),
    .pushValid(pushValid),
    .pushReady(pushReady),
    .pushData (pushData),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // A zero length still moves one beat
  function automatic int burstLength(int beats);
    return (beats == 0) ? 1 : beats;
  endfunction

  // Flow number on top and sequence number below
  function automatic dataWordT makeBeat(int flow, int seq);
    dataWordT word;
    word = '0;
    word[SeqWidth-1:0] = seq[SeqWidth-1:0];
    word[`DATA_WIDTH-1 -: FlowIdxWidth] = flow[FlowIdxWidth-1:0];
    return word;
  endfunction

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic failRun(string what);
    $display("ERROR %s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic addRow(int flow, int beats, int hold);
    rowFlow.push_back(flow);
    rowBeats.push_back(beats);
    rowHold.push_back(hold);
    rowStalled.push_back(1'b0);
  endtask

  // ----------------------------------------------------------
  // Stimulus table (flow, beats, pop stall cycles)
  // ----------------------------------------------------------
  task automatic loadTable();
    addRow(0, 3, 0);
    addRow(2, 1, 0);
    // Zero length row
    addRow(1, 0, 0);
    addRow(3, 15, 6);
    addRow(2, 4, 0);
    addRow(2, 2, 0);
    addRow(0, 7, 8);
    addRow(1, 5, 0);
    addRow(3, 1, 0);
    addRow(0, 0, 4);
    addRow(1, 15, 0);
    addRow(2, 9, 5);
  endtask

  // Expected beats in table order with per flow counters
  task automatic buildExpected();
    int counters[`NUM_FLOWS];
    for (int k = 0; k < `NUM_FLOWS; k++) begin
      counters[k] = 0;
    end
    for (int r = 0; r < rowFlow.size(); r++) begin
      for (int b = 0; b < burstLength(rowBeats[r]); b++) begin
        expWord.push_back(makeBeat(rowFlow[r], counters[rowFlow[r]]));
        expRow.push_back(r);
        counters[rowFlow[r]]++;
      end
    end
    totalBeats = expWord.size();
  endtask

  // ----------------------------------------------------------
  // Drive phase just after the rising edge
  // ----------------------------------------------------------
  task automatic driveInputs();
    if (cmdXfer) begin
      cmdIdx++;
    end
    for (int k = 0; k < `NUM_FLOWS; k++) begin
      if (pushXfer[k]) begin
        seqNext[k]++;
        pushCount++;
        // Push side of the row is complete
        if (pushCount == burstLength(rowBeats[pushRow])) begin
          pushRow++;
          pushCount = 0;
        end
      end
      // A source keeps valid and data until its beat is taken
      if (!pushValid[k] || pushXfer[k]) begin
        rngState     = xorshift32(rngState);
        pushValid[k] = (rngState[1:0] != 2'b00);
      end
      pushData[k] = makeBeat(k, seqNext[k]);
    end
    cmdValid = (cmdIdx < rowFlow.size());
    if (cmdValid) begin
      cmd.flow  = flowIdxT'(rowFlow[cmdIdx]);
      cmd.beats = beatCountT'(rowBeats[cmdIdx]);
    end
    // Sink stalls for a long time at the start of some rows
    if (stallLeft > 0) begin
      stallLeft--;
      popReady = 1'b0;
    end else if (popCount < totalBeats && rowHold[expRow[0]] > 0 && !rowStalled[expRow[0]]) begin
      rowStalled[expRow[0]] = 1'b1;
      stallLeft = rowHold[expRow[0]] - 1;
      popReady  = 1'b0;
    end else begin
      rngState = xorshift32(rngState);
      popReady = (rngState[2:0] != 3'b000);
    end
  endtask

  // ----------------------------------------------------------
  // Sample phase at the falling edge
  // ----------------------------------------------------------
  task automatic sampleOutputs();
    logic [`NUM_FLOWS-1:0] allowed;
    allowed = '0;
    if (pushRow < rowFlow.size()) begin
      allowed[rowFlow[pushRow]] = 1'b1;
    end
    checkValue("pushReady outside the active row", 0, pushReady & ~allowed);
    // Output register must hold under back-pressure
    if (prevPopValid && !prevPopReady) begin
      checkValue("popValid under back-pressure", 1, popValid);
      checkValue("popData under back-pressure", prevPopData, popData);
    end
    cmdXfer  = cmdValid && cmdReady;
    pushXfer = pushValid & pushReady;
    popXfer  = popValid && popReady;
    if (popXfer) begin
      checkValue($sformatf("row %0d beat %0d", expRow[0], popCount), expWord[0], popData);
      void'(expWord.pop_front());
      void'(expRow.pop_front());
      popCount++;
    end
    prevPopValid = popValid;
    prevPopReady = popReady;
    prevPopData  = popData;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    clk          = 1'b0;
    arstN        = 1'b0;
    cmdValid     = 1'b0;
    cmd          = '0;
    pushValid    = '0;
    pushData     = '0;
    popReady     = 1'b0;
    rngState     = 32'd5;
    cmdIdx       = 0;
    pushRow      = 0;
    pushCount    = 0;
    popCount     = 0;
    stallLeft    = 0;
    cmdXfer      = 1'b0;
    pushXfer     = '0;
    popXfer      = 1'b0;
    prevPopValid = 1'b0;
    prevPopReady = 1'b0;
    prevPopData  = '0;
    for (int k = 0; k < `NUM_FLOWS; k++) begin
      seqNext[k] = 0;
    end
    loadTable();
    buildExpected();
    repeat (2) @(posedge clk);
    #(DriveDelay);
    arstN = 1'b1;
    // Idle state right after reset
    @(negedge clk);
    checkValue("reset popValid", 0, popValid);
    checkValue("reset pushReady", 0, pushReady);
    checkValue("reset cmdReady", 1, cmdReady);
    while (popCount < totalBeats) begin
      @(posedge clk);
      #(DriveDelay);
      driveInputs();
      @(negedge clk);
      sampleOutputs();
    end
    // No stray beat after the table is done
    repeat (5) begin
      @(negedge clk);
      if (popValid) begin
        failRun("the switch raised popValid after the last expected beat");
      end
    end
    $display("Everything OK");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int limitCycles;
    #1;
    limitCycles = MarginCycles;
    for (int r = 0; r < rowBeats.size(); r++) begin
      limitCycles += burstLength(rowBeats[r]) * CyclesPerBeat;
    end
    #(limitCycles * ClkPeriod);
    $display("ERROR the switch stopped delivering beats, only %0d of %0d arrived in time",
             popCount, totalBeats);
    $display("Something failed");
    $fatal(1);
  end

endmodule : streamSwitchTb

// ==== sources.f ====
+incdir+hdl
hdl/flowPkg.sv
hdl/cmdPkg.sv
hdl/flowRegFwd.sv
hdl/burstSelectDecode.sv
hdl/flowMuxSelectUnstable.sv
hdl/streamSwitch.sv
bench/streamSwitchTb.sv

// ==== Bender.yml ====
package:
  name: stream_switch

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/flowPkg.sv
      - hdl/cmdPkg.sv
      - hdl/flowRegFwd.sv
      - hdl/burstSelectDecode.sv
      - hdl/flowMuxSelectUnstable.sv
      - hdl/streamSwitch.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/streamSwitchTb.sv
